// File: source/asin_pkg.sv
package asin_pkg;

    // Single precision field widths
    localparam int FP_WIDTH  = 32;
    localparam int EXP_WIDTH = 8;
    localparam int MNT_WIDTH = 23;

    // Exponent bias and the all-ones exponent of infinity
    localparam logic [EXP_WIDTH-1:0] EXP_BIAS = 8'd127;
    localparam logic [EXP_WIDTH-1:0] EXP_MAX  = 8'd255;

    ////////////////////
    // Float word
    ////////////////////

    // Raw word on ports, split fields inside the arithmetic
    typedef union packed {
        logic [FP_WIDTH-1:0] bits;
        struct packed {
            logic                 sign;
            logic [EXP_WIDTH-1:0] exp;
            logic [MNT_WIDTH-1:0] mnt;
        } fields;
    } fp_word_t;

    // Series constants
    localparam fp_word_t FP_ZERO  = 32'h0000_0000;
    localparam fp_word_t FP_THREE = 32'h4040_0000;
    localparam fp_word_t FP_SIX   = 32'h40C0_0000;
    localparam fp_word_t FP_FORTY = 32'h4220_0000;

endpackage

// File: source/fp_mul.sv
`timescale 1ns/1ps

module fp_mul
    import asin_pkg::*;
(
    input  logic     clock,
    input  logic     i_rst,
    input  logic     i_start,
    input  fp_word_t i_a,
    input  fp_word_t i_b,
    output logic     o_done,
    output fp_word_t o_p
);

    localparam int PROD_WIDTH = 2 * (MNT_WIDTH + 1);

    logic [PROD_WIDTH-1:0] prod;
    logic [MNT_WIDTH:0]    mnt;
    logic [EXP_WIDTH-1:0]  exp;
    fp_word_t              res;

    always_comb
    begin
        // Mantissas with their hidden ones
        prod = {1'b1, i_a.fields.mnt} * {1'b1, i_b.fields.mnt};
        // Upper half kept, lower half dropped without rounding
        mnt = prod[PROD_WIDTH-1:MNT_WIDTH+1];
        // Product point sits one bit above the kept MSB, so bias minus one
        exp = i_a.fields.exp + i_b.fields.exp - (EXP_BIAS - 8'd1);
        // Leading-one search
        for (int i = 0; i <= MNT_WIDTH; i++)
        begin
            if (!mnt[MNT_WIDTH])
            begin
                mnt = mnt << 1;
                exp = exp - 8'd1;
            end
        end
        res.fields.sign = i_a.fields.sign ^ i_b.fields.sign;
        res.fields.exp  = exp;
        res.fields.mnt  = mnt[MNT_WIDTH-1:0];
        // Any zero operand forces +0
        if (i_a.bits[FP_WIDTH-2:0] == '0 || i_b.bits[FP_WIDTH-2:0] == '0)
            res = FP_ZERO;
    end

    always_ff @(posedge clock)
    begin
        if (i_rst)
            o_done <= 1'b0;
        else
            o_done <= i_start;
        if (i_start)
            o_p <= res;
    end

endmodule

// File: source/fp_div.sv
`timescale 1ns/1ps

module fp_div
    import asin_pkg::*;
#(
    parameter fp_word_t DIVISOR = FP_SIX
)
(
    input  logic     clock,
    input  logic     i_rst,
    input  logic     i_start,
    input  fp_word_t i_a,
    output logic     o_done,
    output fp_word_t o_q
);

    localparam int                   QUO_WIDTH = MNT_WIDTH + 3;
    localparam logic [3:0]           LAST_PAIR = 4'd13;
    localparam logic [MNT_WIDTH+1:0] DVS       = {2'b01, DIVISOR.fields.mnt};
    // Fixed divisor special cases
    localparam logic DIV_BY_INF  = (DIVISOR.fields.exp == EXP_MAX);
    localparam logic DIV_BY_ZERO = (DIVISOR.fields.exp == '0);

    logic                   busy;
    logic [3:0]             pair_cnt;
    logic                   sign_q;
    logic                   a_inf_q;
    logic [EXP_WIDTH:0]     exp_q;
    logic [MNT_WIDTH+1:0]   rem_q;
    logic [MNT_WIDTH+1:0]   rem_next;
    logic [MNT_WIDTH+1:0]   trial;
    logic [1:0]             pair;
    logic [QUO_WIDTH-1:0]   quo_q;
    logic [QUO_WIDTH-1:0]   quo_inc;
    logic [EXP_WIDTH:0]     exp_fin;
    logic [MNT_WIDTH-1:0]   mnt_fin;
    logic                   shift_en;
    fp_word_t               res;

    // Shift on the start cycle and on every pair after it
    assign shift_en = i_start || (busy && pair_cnt != LAST_PAIR);

    ////////////////////
    // Two restoring steps
    ////////////////////

    always_comb
    begin
        // Start cycle works from the dividend with its hidden one
        rem_next = i_start ? {2'b01, i_a.fields.mnt} : rem_q;
        for (int k = 0; k < 2; k++)
        begin
            trial = rem_next - DVS;
            // Positive trial means the divisor fits
            pair[1-k] = !trial[MNT_WIDTH+1];
            if (!trial[MNT_WIDTH+1])
                rem_next = trial;
            rem_next = {rem_next[MNT_WIDTH:0], 1'b0};
        end
    end

    always_comb
    begin
        // Increment before the quotient window is chosen
        quo_inc = quo_q + 1'b1;
        if (quo_inc[QUO_WIDTH-1])
        begin
            mnt_fin = quo_inc[QUO_WIDTH-2:2];
            exp_fin = exp_q;
        end
        else
        begin
            mnt_fin = quo_inc[QUO_WIDTH-3:1];
            exp_fin = exp_q - 1'b1;
        end
        res.fields.sign = sign_q;
        res.fields.exp  = exp_fin[EXP_WIDTH-1:0];
        res.fields.mnt  = mnt_fin;
        // Bit 8 set means out of range, bit 7 tells which side
        if (exp_fin[EXP_WIDTH])
        begin
            res.fields.exp = exp_fin[EXP_WIDTH-1] ? '0 : EXP_MAX;
            res.fields.mnt = '0;
        end
        if (DIV_BY_INF)
        begin
            res.fields.exp = '0;
            res.fields.mnt = '0;
        end
        else if (DIV_BY_ZERO || a_inf_q)
        begin
            res.fields.exp = EXP_MAX;
            res.fields.mnt = '0;
        end
    end

    always_ff @(posedge clock)
    begin
        if (i_rst)
        begin
            busy     <= 1'b0;
            pair_cnt <= '0;
            o_done   <= 1'b0;
        end
        else
        begin
            o_done <= 1'b0;
            if (i_start)
            begin
                busy     <= 1'b1;
                pair_cnt <= 4'd1;
            end
            else if (busy && pair_cnt == LAST_PAIR)
            begin
                busy   <= 1'b0;
                o_done <= 1'b1;
            end
            else if (busy)
                pair_cnt <= pair_cnt + 4'd1;
        end
    end

    always_ff @(posedge clock)
    begin
        if (i_start)
        begin
            sign_q  <= i_a.fields.sign ^ DIVISOR.fields.sign;
            a_inf_q <= (i_a.fields.exp == EXP_MAX);
            exp_q   <= {1'b0, i_a.fields.exp} - {1'b0, DIVISOR.fields.exp}
                       + {1'b0, EXP_BIAS};
        end
        if (shift_en)
        begin
            rem_q <= rem_next;
            quo_q <= {quo_q[QUO_WIDTH-3:0], pair};
        end
        if (busy && pair_cnt == LAST_PAIR)
            o_q <= res;
    end

    // Owner waits for o_done before the next start
    assert property (@(posedge clock) disable iff (i_rst) busy |-> !i_start);

endmodule

// File: source/fp_add.sv
`timescale 1ns/1ps

module fp_add
    import asin_pkg::*;
(
    input  logic     clock,
    input  logic     i_rst,
    input  logic     i_start,
    input  fp_word_t i_a,
    input  fp_word_t i_b,
    output logic     o_done,
    output fp_word_t o_s
);

    logic [MNT_WIDTH:0]   a_mnt;
    logic [MNT_WIDTH:0]   b_mnt;
    logic [MNT_WIDTH:0]   big_mnt;
    logic [MNT_WIDTH:0]   small_mnt;
    logic [MNT_WIDTH+1:0] sum;
    logic [EXP_WIDTH-1:0] exp;
    logic                 a_smaller;
    logic                 sign;
    fp_word_t             res;

    always_comb
    begin
        a_mnt = {1'b1, i_a.fields.mnt};
        b_mnt = {1'b1, i_b.fields.mnt};
        // Magnitude compare by exponent first, then mantissa
        a_smaller = (i_a.fields.exp < i_b.fields.exp)
                    || (i_a.fields.exp == i_b.fields.exp && i_a.fields.mnt < i_b.fields.mnt);
        // Larger exponent first, other mantissa aligned by truncating shift
        if (i_a.fields.exp >= i_b.fields.exp)
        begin
            big_mnt   = a_mnt;
            small_mnt = b_mnt >> (i_a.fields.exp - i_b.fields.exp);
            exp       = i_a.fields.exp + 8'd1;
        end
        else
        begin
            big_mnt   = b_mnt;
            small_mnt = a_mnt >> (i_b.fields.exp - i_a.fields.exp);
            exp       = i_b.fields.exp + 8'd1;
        end
        // Effective add or subtract of magnitudes
        if (i_a.fields.sign == i_b.fields.sign)
            sum = big_mnt + small_mnt;
        else if (big_mnt >= small_mnt)
            sum = big_mnt - small_mnt;
        else
            sum = small_mnt - big_mnt;
        // Same signs keep it, mixed signs follow the larger magnitude
        if (i_a.fields.sign == i_b.fields.sign)
            sign = i_a.fields.sign;
        else
            sign = i_a.fields.sign ^ a_smaller;
        // Exponent was taken one high, so the sum MSB is the hidden one
        for (int i = 0; i <= MNT_WIDTH; i++)
        begin
            if (!sum[MNT_WIDTH+1])
            begin
                sum = sum << 1;
                exp = exp - 8'd1;
            end
        end
        res.fields.sign = sign;
        res.fields.exp  = exp;
        res.fields.mnt  = sum[MNT_WIDTH:1];
        // Zero operand passes the other one through
        if (i_a.bits[FP_WIDTH-2:0] == '0)
            res = i_b;
        else if (i_b.bits[FP_WIDTH-2:0] == '0)
            res = i_a;
    end

    always_ff @(posedge clock)
    begin
        if (i_rst)
            o_done <= 1'b0;
        else
            o_done <= i_start;
        if (i_start)
            o_s <= res;
    end

endmodule

// File: source/asin_cubic_term.sv
`timescale 1ns/1ps

module asin_cubic_term
    import asin_pkg::*;
#(
    parameter fp_word_t DIVISOR = FP_SIX
)
(
    input  logic     clock,
    input  logic     i_rst,
    input  logic     i_start,
    input  fp_word_t i_x,
    output logic     o_done,
    output fp_word_t o_term
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_MUL      = 3'd1;
    localparam logic [2:0] S_MUL_WAIT = 3'd2;
    localparam logic [2:0] S_DIV      = 3'd3;
    localparam logic [2:0] S_DIV_WAIT = 3'd4;

    logic [2:0] state;
    logic       step;
    logic       mul_start;
    logic       mul_done;
    logic       div_start;
    fp_word_t   x_q;
    fp_word_t   mul_a;
    fp_word_t   mul_p;

    assign mul_start = (state == S_MUL);
    assign div_start = (state == S_DIV);
    // Step 0 squares x, step 1 multiplies the square by x
    assign mul_a     = step ? mul_p : x_q;

    fp_mul u_mul (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_a     (mul_a),
        .i_b     (x_q),
        .o_done  (mul_done),
        .o_p     (mul_p)
    );

    // Divides the held cube
    fp_div #(
        .DIVISOR (DIVISOR)
    ) u_div (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_start (div_start),
        .i_a     (mul_p),
        .o_done  (o_done),
        .o_q     (o_term)
    );

    always_ff @(posedge clock)
    begin
        if (i_rst)
        begin
            state <= S_IDLE;
            step  <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (i_start)
                    begin
                        state <= S_MUL;
                        step  <= 1'b0;
                    end
                S_MUL:
                    state <= S_MUL_WAIT;
                S_MUL_WAIT:
                    if (mul_done)
                    begin
                        // After the cube go on to the divide
                        state <= step ? S_DIV : S_MUL;
                        step  <= 1'b1;
                    end
                S_DIV:
                    state <= S_DIV_WAIT;
                S_DIV_WAIT:
                    if (o_done)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
        if (state == S_IDLE && i_start)
            x_q <= i_x;
    end

    // One argument in flight, so no restart while a term is reported
    assert property (@(posedge clock) disable iff (i_rst) i_start |-> !o_done);

endmodule

// File: source/asin_quintic_term.sv
`timescale 1ns/1ps

module asin_quintic_term
    import asin_pkg::*;
#(
    parameter fp_word_t SCALE   = FP_THREE,
    parameter fp_word_t DIVISOR = FP_FORTY
)
(
    input  logic     clock,
    input  logic     i_rst,
    input  logic     i_start,
    input  fp_word_t i_x,
    output logic     o_done,
    output fp_word_t o_term
);

    localparam logic [2:0] S_IDLE     = 3'd0;
    localparam logic [2:0] S_MUL      = 3'd1;
    localparam logic [2:0] S_MUL_WAIT = 3'd2;
    localparam logic [2:0] S_DIV      = 3'd3;
    localparam logic [2:0] S_DIV_WAIT = 3'd4;
    localparam logic [1:0] LAST_STEP  = 2'd3;

    logic [2:0] state;
    logic [1:0] step;
    logic       mul_start;
    logic       mul_done;
    logic       div_start;
    fp_word_t   x_q;
    fp_word_t   x2_q;
    fp_word_t   x3_q;
    fp_word_t   mul_a;
    fp_word_t   mul_b;
    fp_word_t   mul_p;

    assign mul_start = (state == S_MUL);
    assign div_start = (state == S_DIV);

    ////////////////////
    // Operands by step
    ////////////////////

    always_comb
    begin
        case (step)
            2'd0:
            begin
                mul_a = x_q;
                mul_b = x_q;
            end
            2'd1:
            begin
                mul_a = x2_q;
                mul_b = x_q;
            end
            // x^5 as x^2 times x^3
            2'd2:
            begin
                mul_a = x2_q;
                mul_b = x3_q;
            end
            default:
            begin
                mul_a = mul_p;
                mul_b = SCALE;
            end
        endcase
    end

    fp_mul u_mul (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_start (mul_start),
        .i_a     (mul_a),
        .i_b     (mul_b),
        .o_done  (mul_done),
        .o_p     (mul_p)
    );

    fp_div #(
        .DIVISOR (DIVISOR)
    ) u_div (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_start (div_start),
        .i_a     (mul_p),
        .o_done  (o_done),
        .o_q     (o_term)
    );

    always_ff @(posedge clock)
    begin
        if (i_rst)
        begin
            state <= S_IDLE;
            step  <= 2'd0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (i_start)
                    begin
                        state <= S_MUL;
                        step  <= 2'd0;
                    end
                S_MUL:
                    state <= S_MUL_WAIT;
                S_MUL_WAIT:
                    if (mul_done && step == LAST_STEP)
                        state <= S_DIV;
                    else if (mul_done)
                    begin
                        state <= S_MUL;
                        step  <= step + 2'd1;
                    end
                S_DIV:
                    state <= S_DIV_WAIT;
                S_DIV_WAIT:
                    if (o_done)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
        end
        if (state == S_IDLE && i_start)
            x_q <= i_x;
        // Powers kept for the later steps
        if (mul_done && step == 2'd0)
            x2_q <= mul_p;
        if (mul_done && step == 2'd1)
            x3_q <= mul_p;
    end

endmodule

// File: source/asin_series_sum.sv
`timescale 1ns/1ps

module asin_series_sum
    import asin_pkg::*;
(
    input  logic     clock,
    input  logic     i_rst,
    input  logic     i_start,
    input  fp_word_t i_x,
    input  logic     i_cubic_done,
    input  fp_word_t i_cubic,
    input  logic     i_quintic_done,
    input  fp_word_t i_quintic,
    input  logic     i_ready,
    output logic     o_valid,
    output fp_word_t o_asin,
    output logic     o_busy
);

    localparam logic [2:0] S_IDLE  = 3'd0;
    localparam logic [2:0] S_TERMS = 3'd1;
    localparam logic [2:0] S_SUM1  = 3'd2;
    localparam logic [2:0] S_SUM2  = 3'd3;
    localparam logic [2:0] S_HOLD  = 3'd4;

    logic [2:0] state;
    logic       have_cubic;
    logic       have_quintic;
    logic       add_start;
    logic       add_done;
    fp_word_t   x_q;
    fp_word_t   cubic_q;
    fp_word_t   quintic_q;
    fp_word_t   add_a;
    fp_word_t   add_b;

    // First sum once both terms are in, second on the first done
    assign add_start = (state == S_TERMS && have_cubic && have_quintic)
                       || (state == S_SUM1 && add_done);
    // Second pass adds x to the held partial sum
    assign add_a     = (state == S_SUM1) ? x_q : cubic_q;
    assign add_b     = (state == S_SUM1) ? o_asin : quintic_q;
    assign o_valid   = (state == S_HOLD);
    assign o_busy    = (state != S_IDLE);

    // Adder output holds until the next start, so it is the result word
    fp_add u_add (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_start (add_start),
        .i_a     (add_a),
        .i_b     (add_b),
        .o_done  (add_done),
        .o_s     (o_asin)
    );

    always_ff @(posedge clock)
    begin
        if (i_rst)
        begin
            state        <= S_IDLE;
            have_cubic   <= 1'b0;
            have_quintic <= 1'b0;
        end
        else
        begin
            case (state)
                S_IDLE:
                    if (i_start)
                        state <= S_TERMS;
                S_TERMS:
                    if (add_start)
                        state <= S_SUM1;
                S_SUM1:
                    if (add_done)
                        state <= S_SUM2;
                S_SUM2:
                    if (add_done)
                        state <= S_HOLD;
                S_HOLD:
                    if (i_ready)
                        state <= S_IDLE;
                default:
                    state <= S_IDLE;
            endcase
            // Terms arrive in either order
            if (i_start)
            begin
                have_cubic   <= 1'b0;
                have_quintic <= 1'b0;
            end
            else
            begin
                if (i_cubic_done)
                    have_cubic <= 1'b1;
                if (i_quintic_done)
                    have_quintic <= 1'b1;
            end
        end
        if (i_start)
            x_q <= i_x;
        if (i_cubic_done)
            cubic_q <= i_cubic;
        if (i_quintic_done)
            quintic_q <= i_quintic;
    end

    // No new addition may disturb a result that waits for the consumer
    assert property (@(posedge clock) disable iff (i_rst)
        o_valid && !i_ready |=> o_valid && $stable(o_asin));

endmodule

// File: source/asin_top.sv
`timescale 1ns/1ps

module asin_top
    import asin_pkg::*;
#(
    parameter fp_word_t CUBIC_DIVISOR   = FP_SIX,
    parameter fp_word_t QUINTIC_SCALE   = FP_THREE,
    parameter fp_word_t QUINTIC_DIVISOR = FP_FORTY
)
(
    input  logic                clock,
    input  logic                i_rst,
    input  logic                i_valid,
    output logic                o_ready,
    input  logic [FP_WIDTH-1:0] i_x,
    output logic                o_valid,
    input  logic                i_ready,
    output logic [FP_WIDTH-1:0] o_asin
);

    logic     accept;
    logic     busy;
    logic     cubic_done;
    logic     quintic_done;
    fp_word_t cubic_term;
    fp_word_t quintic_term;

    // Ready only with nothing in flight and no result waiting
    assign o_ready = !busy;
    // Accept pulse starts all three parts together
    assign accept  = i_valid && o_ready;

    asin_cubic_term #(
        .DIVISOR (CUBIC_DIVISOR)
    ) u_cubic (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_start (accept),
        .i_x     (i_x),
        .o_done  (cubic_done),
        .o_term  (cubic_term)
    );

    asin_quintic_term #(
        .SCALE   (QUINTIC_SCALE),
        .DIVISOR (QUINTIC_DIVISOR)
    ) u_quintic (
        .clock   (clock),
        .i_rst   (i_rst),
        .i_start (accept),
        .i_x     (i_x),
        .o_done  (quintic_done),
        .o_term  (quintic_term)
    );

    asin_series_sum u_sum (
        .clock          (clock),
        .i_rst          (i_rst),
        .i_start        (accept),
        .i_x            (i_x),
        .i_cubic_done   (cubic_done),
        .i_cubic        (cubic_term),
        .i_quintic_done (quintic_done),
        .i_quintic      (quintic_term),
        .i_ready        (i_ready),
        .o_valid        (o_valid),
        .o_asin         (o_asin),
        .o_busy         (busy)
    );

endmodule

// File: tb/clock_gen.sv
`timescale 1ns/1ps

module clock_gen
(
    output logic o_clock,
    output logic o_rst
);

    // 20 ns period
    initial
    begin
        o_clock = 1'b0;
        forever #10 o_clock = ~o_clock;
    end

    // Reset held over the first two rising edges
    initial
    begin
        o_rst = 1'b1;
        repeat (2) @(posedge o_clock);
        o_rst <= 1'b0;
    end

endmodule

// File: tb/asin_tb.sv
`timescale 1ns/1ps

module asin_tb;

    localparam int MAX_LINES   = 32;
    localparam int TEST_CYCLES = 400;

    logic        clock;
    logic        rst;
    logic        i_valid;
    logic        o_ready;
    logic [31:0] i_x;
    logic        o_valid;
    logic        i_ready;
    logic [31:0] o_asin;

    // Trace contents
    logic [8*24-1:0] names [MAX_LINES];
    logic [31:0]     xs    [MAX_LINES];
    logic [31:0]     exps  [MAX_LINES];
    int              holds [MAX_LINES];
    int              n_lines;

    int          pass_count;
    int          fail_count;
    int          transfers;
    int          expected_transfers;
    logic [31:0] rng;
    bit          loaded;

    clock_gen u_clk (
        .o_clock (clock),
        .o_rst   (rst)
    );

    asin_top dut (
        .clock   (clock),
        .i_rst   (rst),
        .i_valid (i_valid),
        .o_ready (o_ready),
        .i_x     (i_x),
        .o_valid (o_valid),
        .i_ready (i_ready),
        .o_asin  (o_asin)
    );

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] v;
        v = s;
        v = v ^ (v << 13);
        v = v ^ (v >> 17);
        v = v ^ (v << 5);
        return v;
    endfunction

    ////////////////////
    // Trace reader
    ////////////////////

    task automatic load_trace;
        int              fd;
        int              r;
        string           line;
        logic [8*24-1:0] nm;
        logic [31:0]     a;
        logic [31:0]     b;
        int              h;
        n_lines = 0;
        fd = $fopen("tb/asin_trace.txt", "r");
        if (fd == 0)
        begin
            $display("cannot open the trace file tb/asin_trace.txt");
            fail_count++;
        end
        else
        begin
            while (!$feof(fd))
            begin
                r = $fgets(line, fd);
                // Comment lines start with a hash
                if (r > 0 && line.len() > 1 && line[0] != 8'h23)
                begin
                    r = $sscanf(line, "%s %h %h %d", nm, a, b, h);
                    if (r == 4 && n_lines < MAX_LINES)
                    begin
                        names[n_lines] = nm;
                        xs[n_lines]    = a;
                        exps[n_lines]  = b;
                        holds[n_lines] = h;
                        n_lines++;
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    ////////////////////
    // One argument through the DUT
    ////////////////////

    task automatic run_test(input logic [8*24-1:0] name, input logic [31:0] x,
                            input logic [31:0] exp_word, input int hold, input bit negated);
        int          wait_cnt;
        logic [31:0] first;
        bit          ok;
        ok = 1'b1;
        wait_cnt = 0;
        @(negedge clock);
        while (!o_ready && wait_cnt < TEST_CYCLES)
        begin
            @(negedge clock);
            wait_cnt++;
        end
        if (!o_ready)
        begin
            $display("%0s: DUT never became ready for a new argument", name);
            fail_count++;
            return;
        end
        @(posedge clock);
        i_valid <= 1'b1;
        i_x     <= x;
        i_ready <= (hold == 0);
        @(posedge clock);
        i_valid <= 1'b0;
        // Result end is marked by o_valid only
        wait_cnt = 0;
        @(negedge clock);
        while (!o_valid && wait_cnt < TEST_CYCLES)
        begin
            @(negedge clock);
            wait_cnt++;
        end
        if (!o_valid)
        begin
            $display("%0s: timed out waiting for a result", name);
            fail_count++;
            return;
        end
        expected_transfers++;
        first = o_asin;
        for (int i = 0; i < hold; i++)
        begin
            if (!o_valid || o_asin !== first || o_ready)
                ok = 1'b0;
            @(posedge clock);
            if (i == hold - 1)
                i_ready <= 1'b1;
            @(negedge clock);
        end
        // Transfer happens on the next rising edge
        if (!o_valid || o_asin !== first)
            ok = 1'b0;
        @(posedge clock);
        if (!ok)
        begin
            $display("%0s: result was not held steady under back-pressure", name);
            fail_count++;
        end
        else if (first !== exp_word)
        begin
            $display("error %0s%0s expected %h actual %h", name,
                     negated ? " negated" : "", exp_word, first);
            fail_count++;
        end
        else
        begin
            $display("pass %0s%0s", name, negated ? " negated" : "");
            pass_count++;
        end
    endtask

    // Counts every handshake on the output side
    always @(posedge clock)
    begin
        if (!rst && o_valid && i_ready)
            transfers++;
    end

    // Watchdog scaled by the number of tests
    initial
    begin
        wait (loaded);
        repeat ((3 * n_lines + 1) * TEST_CYCLES) @(posedge clock);
        $display("watchdog expired before the tests finished");
        $display("Some tests failed");
        $finish;
    end

    initial
    begin
        int gap;
        int hold;
        i_valid = 1'b0;
        i_x = 32'h0;
        i_ready = 1'b1;
        pass_count = 0;
        fail_count = 0;
        transfers = 0;
        expected_transfers = 0;
        rng = 32'd30;
        load_trace();
        loaded = 1'b1;
        @(negedge clock);
        while (rst)
            @(negedge clock);
        // Idle state right after reset
        if (o_valid || !o_ready)
        begin
            $display("reset_state: o_valid high or o_ready low after reset");
            fail_count++;
        end
        else
        begin
            $display("pass reset_state");
            pass_count++;
        end
        // Directed trace
        for (int i = 0; i < n_lines; i++)
            run_test(names[i], xs[i], exps[i], holds[i], 1'b0);
        // Negated positive arguments give the sign-flipped word
        for (int i = 0; i < n_lines; i++)
        begin
            if (!xs[i][31] && xs[i][30:0] != 31'h0)
                run_test(names[i], {1'b1, xs[i][30:0]}, {~exps[i][31], exps[i][30:0]},
                         holds[i], 1'b1);
        end
        // Stress replay with random gaps and stalls
        for (int i = 0; i < n_lines; i++)
        begin
            rng = xorshift(rng);
            gap = rng % 5;
            repeat (gap) @(posedge clock);
            rng = xorshift(rng);
            hold = rng % 4;
            run_test(names[i], xs[i], exps[i], hold, 1'b0);
        end
        repeat (2) @(posedge clock);
        if (transfers != expected_transfers)
        begin
            $display("stress: %0d results seen for %0d arguments, results lost or duplicated",
                     transfers, expected_transfers);
            fail_count++;
        end
        $display("tests passed %0d failed %0d", pass_count, fail_count);
        if (fail_count == 0)
            $display("All tests passed");
        else
            $display("Some tests failed");
        $finish;
    end

endmodule

// File: tb/asin_trace.txt
# name  input_x  expected_asin  hold_cycles
# words are hex single precision, hold is cycles of i_ready low
zero          00000000 00000000 0
quarter       3E800000 3E815EEE 2
half          3F000000 3F05EEEE 0
three_quarter 3F400000 3F568E66 3
one           3F800000 3F9EEEEE 1
neg_half      BF000000 BF05EEEE 4

// File: asin.f
source/asin_pkg.sv
source/fp_mul.sv
source/fp_div.sv
source/fp_add.sv
source/asin_cubic_term.sv
source/asin_quintic_term.sv
source/asin_series_sum.sv
source/asin_top.sv
tb/clock_gen.sv
tb/asin_tb.sv

// File: Makefile
LOG = sim.log

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator, run the testbench, check the log"
	@echo "  clean  remove build output and log"

test:
	verilator --binary --assert -Wno-fatal --top-module asin_tb -f asin.f \
		-Mdir obj_dir -o asin_sim
	./obj_dir/asin_sim | tee $(LOG)
	grep -q "All tests passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
